/* verilog.f */
+incdir+.
fpu_pkg.sv
fp_classify.sv
fp_compare.sv
fp_select.sv
fpu_top.sv
tb_fpu.sv

/* run.sh */
#!/bin/sh
# Build and run the FPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_fpu -o tb_fpu_sim; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_fpu_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "All checks passed"; then
  exit 0
fi
exit 1

/* tb_fpu_ref.svh */
// FPU reference model
`ifndef TB_FPU_REF_SVH
`define TB_FPU_REF_SVH

// ======================================================================
// Operand facts
// ======================================================================
function automatic bit nan_of(input logic [31:0] x);
  return (x[30:23] == 8'hFF) && (x[22:0] != 23'd0);
endfunction

function automatic bit snan_of(input logic [31:0] x);
  return nan_of(x) && !x[22];  // Quiet bit clear
endfunction

// Unsigned key in numeric order, -0 just below +0
function automatic logic [31:0] order_key(input logic [31:0] x);
  return x[31] ? ~x : (x | 32'h8000_0000);
endfunction

function automatic logic [9:0] class_of(input logic [31:0] x);
  int idx;
  if (nan_of(x)) idx = x[22] ? 9 : 8;
  else if (x[30:23] == 8'hFF) idx = x[31] ? 0 : 7;   // Infinity
  else if (x[30:23] != 8'h00) idx = x[31] ? 1 : 6;   // Normal
  else if (x[22:0] != 23'd0) idx = x[31] ? 2 : 5;    // Subnormal
  else idx = x[31] ? 3 : 4;                          // Zero
  return 10'd1 << idx;
endfunction

function automatic bit op_supported(input fp_op_e op);
  return op inside {FP_SGNJ, FP_SGNJN, FP_SGNJX, FP_MIN, FP_MAX, FP_CMP, FP_CLASS,
                    FP_MV_XW, FP_MV_WX};
endfunction

// ======================================================================
// Expected response
// ======================================================================
function automatic fpu_rsp_t expected_rsp(input fpu_req_t r);
  fpu_rsp_t    e;
  logic [31:0] a;
  logic [31:0] b;
  bit          a_nan;
  bit          b_nan;
  bit          zeros;   // Both zero, any sign
  bit          eq;
  bit          less;
  a     = r.operand_a.raw;
  b     = r.operand_b.raw;
  a_nan = nan_of(a);
  b_nan = nan_of(b);
  zeros = (a[30:0] == 31'd0) && (b[30:0] == 31'd0);
  eq    = !a_nan && !b_nan && ((a == b) || zeros);
  less  = !a_nan && !b_nan && !zeros && (order_key(a) < order_key(b));
  e     = '0;
  case (r.op)
    FP_SGNJ:  e.fp_result = {b[31], a[30:0]};
    FP_SGNJN: e.fp_result = {~b[31], a[30:0]};
    FP_SGNJX: e.fp_result = {a[31] ^ b[31], a[30:0]};
    FP_MIN, FP_MAX: begin
      if (a_nan && b_nan) e.fp_result = CANONICAL_NAN;
      else if (a_nan) e.fp_result = b;
      else if (b_nan) e.fp_result = a;
      else if ((order_key(a) < order_key(b)) == (r.op == FP_MIN)) e.fp_result = a;
      else e.fp_result = b;
      e.flag_nv = snan_of(a) || snan_of(b);
    end
    FP_CMP: begin
      if (r.funct3 == 3'd1) begin          // FLT
        e.int_result[0] = less;
        e.flag_nv       = a_nan || b_nan;
      end else if (r.funct3 == 3'd0) begin // FLE
        e.int_result[0] = less || eq;
        e.flag_nv       = a_nan || b_nan;
      end else begin                       // FEQ and unused codes
        e.int_result[0] = eq;
        e.flag_nv       = snan_of(a) || snan_of(b);
      end
    end
    FP_CLASS: e.int_result = {22'd0, class_of(a)};
    FP_MV_XW: e.int_result = a;
    FP_MV_WX: e.fp_result  = r.int_operand;
    default:  ;
  endcase
  return e;
endfunction

`endif

/* tb_fpu.sv */
// FPU testbench
`timescale 1ns/1ps

module tb_fpu;
  import fpu_pkg::*;

  `include "tb_fpu_ref.svh"

  logic     clk;
  logic     arst_n;
  logic     start;
  fpu_req_t req;
  logic     done;
  fpu_rsp_t rsp;

  fpu_rsp_t exp_q[$];     // Expected responses in issue order
  int       issue_q[$];   // Counter value at each drive edge
  int       cyc = 0;
  int       n_tests = 0;
  int       n_checks = 0;
  int       n_errors = 0;

  localparam fp_op_e      OPS [9]       = '{FP_SGNJ, FP_SGNJN, FP_SGNJX, FP_MIN, FP_MAX,
                                            FP_CMP, FP_CLASS, FP_MV_XW, FP_MV_WX};
  localparam fp_op_e      MOVE_OPS [5]  = '{FP_SGNJ, FP_SGNJN, FP_SGNJX, FP_MV_XW, FP_MV_WX};
  // Directed pairs: signed zeros, NaNs, infinities, subnormals, equal
  localparam logic [31:0] PAIR_A [11]   = '{32'h0000_0000, 32'h8000_0000, 32'h7FC0_0000,
                                            32'h3F80_0000, 32'h7F80_0001, 32'h7FC0_0001,
                                            32'h7F80_0000, 32'hFF80_0000, 32'h0000_0001,
                                            32'h8000_0010, 32'h4040_0000};
  localparam logic [31:0] PAIR_B [11]   = '{32'h8000_0000, 32'h0000_0000, 32'h3F80_0000,
                                            32'h7F80_0001, 32'h7FC0_0000, 32'hFFC0_0000,
                                            32'hFF80_0000, 32'h0000_0001, 32'h0000_0002,
                                            32'h8000_0001, 32'h4040_0000};
  // One operand per class, in mask bit order
  localparam logic [31:0] CLASS_OPS [10] = '{32'hFF80_0000, 32'hBF80_0000, 32'h8000_0001,
                                             32'h8000_0000, 32'h0000_0000, 32'h0000_0001,
                                             32'h3F80_0000, 32'h7F80_0000, 32'h7F80_0001,
                                             32'h7FC0_0000};

  fpu_top u_dut (
    .clk    (clk),
    .arst_n (arst_n),
    .start  (start),
    .req    (req),
    .done   (done),
    .rsp    (rsp)
  );

  // ======================================================================
  // Clock, cycle counter, run limit
  // ======================================================================
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  initial begin
    #1_000_000;
    $display("Simulation time limit reached before the tests finished");
    $display("Checks failed");
    $finish;
  end

  // ======================================================================
  // Helpers
  // ======================================================================
  task automatic check(input string name, input logic [64:0] got, input logic [64:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  function automatic logic [31:0] random_operand();
    logic [31:0] x;
    x = $urandom();
    case ($urandom_range(0, 3))
      0: x[30:23] = 8'h00;       // Zero or subnormal
      1: x[30:23] = 8'hFF;       // Infinity or NaN
      2: x[22:0]  = 23'd0;       // Power of two
      default: ;
    endcase
    return x;
  endfunction

  function automatic fpu_req_t make_req(input fp_op_e op, input logic [2:0] f3,
                                        input logic [31:0] a, input logic [31:0] b);
    fpu_req_t r;
    r.op            = op;
    r.funct3        = f3;
    r.operand_a.raw = a;
    r.operand_b.raw = b;
    r.int_operand   = $urandom();
    return r;
  endfunction

  task automatic drive_req(input fpu_req_t r);
    @(posedge clk);
    start <= 1'b1;
    req   <= r;
    if (op_supported(r.op)) begin  // Unsupported codes expect no done
      exp_q.push_back(expected_rsp(r));
      issue_q.push_back(cyc);
    end
  endtask

  task automatic drop_start();
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic drain_queue();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 20) begin
      @(posedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      n_errors++;
      $display("Timed out at %0t waiting for %0d done pulses", $time, exp_q.size());
      exp_q.delete();
      issue_q.delete();
    end
  endtask

  task automatic run_one(input fpu_req_t r);
    drive_req(r);
    drop_start();
    drain_queue();
  endtask

  task automatic report_test(input string name, input int errs_before);
    n_tests++;
    $display("Test %0d %s finished with %0d errors", n_tests, name, n_errors - errs_before);
  endtask

  // ======================================================================
  // Response comparison
  // ======================================================================
  always @(posedge clk) begin
    fpu_rsp_t e;
    int       c;
    if (arst_n && done) begin
      if (exp_q.size() == 0) begin
        n_errors++;
        $display("Unexpected done pulse at %0t with no request pending", $time);
      end else begin
        e = exp_q.pop_front();
        c = issue_q.pop_front();
        // Drive edge, accept edge, done seen at the following edge
        check("done delay in edges", 65'(cyc - c), 65'd2);
        check("rsp.fp_result", 65'(rsp.fp_result), 65'(e.fp_result));
        check("rsp.int_result", 65'(rsp.int_result), 65'(e.int_result));
        check("rsp.flag_nv", 65'(rsp.flag_nv), 65'(e.flag_nv));
      end
    end
  end

  // ======================================================================
  // Stimulus
  // ======================================================================
  initial begin
    int       errs;
    fpu_rsp_t held;
    void'($urandom(32'h15b0_376e));
    arst_n = 1'b0;
    start  = 1'b0;
    req    = '0;

    errs = n_errors;
    for (int i = 0; i < 16; i++) begin
      @(posedge clk);
      check("done", 65'(done), 65'd0);
      check("rsp", 65'(rsp), 65'd0);
      start <= (i < 15);           // Live request held against reset
      req   <= make_req(FP_MV_XW, 3'd0, 32'h3F80_0000, 32'h4040_0000);
    end
    arst_n <= 1'b1;
    @(posedge clk);
    check("done", 65'(done), 65'd0);
    check("rsp", 65'(rsp), 65'd0);
    report_test("reset state", errs);

    errs = n_errors;
    for (int i = 0; i < 40; i++) begin
      run_one(make_req(MOVE_OPS[i % 5], 3'd0, random_operand(), random_operand()));
    end
    report_test("sign injection and moves", errs);

    errs = n_errors;
    for (int i = 0; i < 11; i++) begin
      run_one(make_req(FP_MIN, 3'd0, PAIR_A[i], PAIR_B[i]));
      run_one(make_req(FP_MAX, 3'd0, PAIR_A[i], PAIR_B[i]));
    end
    for (int i = 0; i < 30; i++) begin
      run_one(make_req((i % 2 == 0) ? FP_MIN : FP_MAX, 3'd0, random_operand(),
                       random_operand()));
    end
    report_test("min max", errs);

    errs = n_errors;
    for (int i = 0; i < 11; i++) begin
      for (int f = 0; f < 4; f++) begin  // FLE, FLT, FEQ, then unused code 5
        run_one(make_req(FP_CMP, (f == 3) ? 3'd5 : 3'(f), PAIR_A[i], PAIR_B[i]));
      end
    end
    for (int i = 0; i < 40; i++) begin
      run_one(make_req(FP_CMP, 3'($urandom_range(0, 7)), random_operand(),
                       random_operand()));
    end
    report_test("compare", errs);

    errs = n_errors;
    for (int k = 0; k < 10; k++) begin
      run_one(make_req(FP_CLASS, 3'd0, CLASS_OPS[k], random_operand()));
      check("rsp.int_result class bit", 65'(rsp.int_result), 65'(32'd1 << k));
    end
    report_test("classify", errs);

    errs = n_errors;
    for (int i = 0; i < 40; i++) begin  // Start stays high across the run
      drive_req(make_req(OPS[$urandom_range(0, 8)], 3'($urandom_range(0, 7)),
                         random_operand(), random_operand()));
    end
    drop_start();
    drain_queue();
    report_test("back to back", errs);

    errs = n_errors;
    held = rsp;
    drive_req(make_req(FP_ADD, 3'd0, random_operand(), random_operand()));
    drop_start();
    @(posedge clk);
    check("done", 65'(done), 65'd0);
    check("rsp", 65'(rsp), 65'(held));
    report_test("unsupported code", errs);

    $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* fpu_top.sv */
// Single-cycle FPU top level
`timescale 1ns/1ps

module fpu_top (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              start,     // Request strobe
  input  fpu_pkg::fpu_req_t req,
  output logic              done,      // One-cycle pulse per accepted op
  output fpu_pkg::fpu_rsp_t rsp
);
  import fpu_pkg::*;

  fp_info_t   a_info;
  fp_info_t   b_info;
  logic [9:0] a_class;       // FCLASS mask of operand a
  cmp_op_e    cmp_op;
  logic [1:0] sgnj_mode;
  logic       is_max;
  logic       lt;
  logic       cmp_true;
  logic       cmp_nv;
  fp32_u      sgnj_result;
  fp32_u      minmax_result;
  logic       minmax_nv;
  fpu_rsp_t   rsp_next;
  logic       op_ok;         // Supported operation code
  logic       accept;

  // ====================================================================
  // Decode
  // ====================================================================
  always_comb begin
    case (req.funct3)
      3'd2:    cmp_op = CMP_FEQ;
      3'd1:    cmp_op = CMP_FLT;
      3'd0:    cmp_op = CMP_FLE;
      default: cmp_op = CMP_FEQ;  // Out-of-range funct3 acts as FEQ
    endcase
  end

  always_comb begin
    case (req.op)
      FP_SGNJN: sgnj_mode = SGNJ_NEG;
      FP_SGNJX: sgnj_mode = SGNJ_XOR;
      default:  sgnj_mode = SGNJ_PLAIN;
    endcase
  end

  assign is_max = (req.op == FP_MAX);

  // ====================================================================
  // Units
  // ====================================================================
  fp_classify u_class_a (
    .operand    (req.operand_a),
    .info       (a_info),
    .class_mask (a_class)
  );

  fp_classify u_class_b (
    .operand    (req.operand_b),
    .info       (b_info),
    .class_mask ()              // FCLASS reads rs1 only
  );

  fp_compare u_compare (
    .a        (req.operand_a),
    .b        (req.operand_b),
    .a_info   (a_info),
    .b_info   (b_info),
    .op       (cmp_op),
    .lt       (lt),
    .cmp_true (cmp_true),
    .flag_nv  (cmp_nv)
  );

  fp_select u_select (
    .a             (req.operand_a),
    .b             (req.operand_b),
    .a_info        (a_info),
    .b_info        (b_info),
    .lt            (lt),
    .sgnj_mode     (sgnj_mode),
    .is_max        (is_max),
    .sgnj_result   (sgnj_result),
    .minmax_result (minmax_result),
    .minmax_nv     (minmax_nv)
  );

  // ====================================================================
  // Result mux and response register
  // ====================================================================
  always_comb begin
    rsp_next = '0;              // Unused fields stay zero
    op_ok    = 1'b1;
    case (req.op)
      FP_SGNJ, FP_SGNJN, FP_SGNJX: rsp_next.fp_result = sgnj_result.raw;
      FP_MIN, FP_MAX: begin
        rsp_next.fp_result = minmax_result.raw;
        rsp_next.flag_nv   = minmax_nv;
      end
      FP_CMP: begin
        rsp_next.int_result = {31'd0, cmp_true};
        rsp_next.flag_nv    = cmp_nv;
      end
      FP_CLASS: rsp_next.int_result = {22'd0, a_class};
      FP_MV_XW: rsp_next.int_result = req.operand_a.raw;  // Plain bit copy
      FP_MV_WX: rsp_next.fp_result  = req.int_operand;
      default:  op_ok = 1'b0;   // Arithmetic and unknown codes ignored
    endcase
  end

  assign accept = start & op_ok;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      done <= 1'b0;
      rsp  <= '0;
    end else begin
      done <= accept;
      if (accept) rsp <= rsp_next;  // Held until next accepted op
    end
  end

endmodule

/* fp_select.sv */
// Sign injection and min/max selector
`timescale 1ns/1ps

module fp_select (
  input  fpu_pkg::fp32_u    a,
  input  fpu_pkg::fp32_u    b,
  input  fpu_pkg::fp_info_t a_info,
  input  fpu_pkg::fp_info_t b_info,
  input  logic              lt,             // From comparator
  input  logic [1:0]        sgnj_mode,
  input  logic              is_max,
  output fpu_pkg::fp32_u    sgnj_result,
  output fpu_pkg::fp32_u    minmax_result,
  output logic              minmax_nv
);
  import fpu_pkg::*;

  logic inj_sign;
  logic a_nan;
  logic b_nan;
  logic pick_b;     // Take b over a when neither is NaN

  // ====================================================================
  // Sign injection
  // ====================================================================
  always_comb begin
    case (sgnj_mode)
      SGNJ_PLAIN: inj_sign = b.fields.sign;
      SGNJ_NEG:   inj_sign = ~b.fields.sign;
      SGNJ_XOR:   inj_sign = a.fields.sign ^ b.fields.sign;
      default:    inj_sign = b.fields.sign;
    endcase
  end

  // Exponent and mantissa always from a, NaN payload included
  assign sgnj_result.raw = {inj_sign, a.raw[30:0]};

  // ====================================================================
  // Min / max
  // ====================================================================
  assign a_nan = a_info.is_snan | a_info.is_qnan;
  assign b_nan = b_info.is_snan | b_info.is_qnan;

  // lt puts -0 below +0, so signed zeros resolve here too
  assign pick_b = is_max ? lt : ~lt;

  always_comb begin
    if (a_nan && b_nan) begin
      minmax_result.raw = CANONICAL_NAN;
    end else if (a_nan) begin
      minmax_result = b;      // Number wins over NaN
    end else if (b_nan) begin
      minmax_result = a;
    end else if (pick_b) begin
      minmax_result = b;
    end else begin
      minmax_result = a;
    end
  end

  // Quiet NaN alone does not raise invalid
  assign minmax_nv = a_info.is_snan | b_info.is_snan;

endmodule

/* fp_compare.sv */
// Floating-point comparator
`timescale 1ns/1ps

module fp_compare (
  input  fpu_pkg::fp32_u    a,
  input  fpu_pkg::fp32_u    b,
  input  fpu_pkg::fp_info_t a_info,
  input  fpu_pkg::fp_info_t b_info,
  input  fpu_pkg::cmp_op_e  op,
  output logic              lt,         // a strictly below b, -0 below +0
  output logic              cmp_true,
  output logic              flag_nv
);
  import fpu_pkg::*;

  logic any_nan;
  logic any_snan;
  logic both_zero;   // Either sign of zero on both sides
  logic mag_lt;      // |a| < |b|
  logic mag_gt;      // |a| > |b|
  logic ord_eq;      // IEEE equality, non-NaN
  logic ord_lt;      // IEEE less-than, non-NaN

  assign any_nan   = a_info.is_snan | a_info.is_qnan | b_info.is_snan | b_info.is_qnan;
  assign any_snan  = a_info.is_snan | b_info.is_snan;
  assign both_zero = a_info.is_zero & b_info.is_zero;

  // Exponent and mantissa order like an unsigned integer
  assign mag_lt = (a.raw[30:0] < b.raw[30:0]);
  assign mag_gt = (a.raw[30:0] > b.raw[30:0]);

  // ====================================================================
  // Total order by sign and magnitude
  // ====================================================================
  always_comb begin
    if (a.fields.sign != b.fields.sign) begin
      lt = a.fields.sign;       // Negative side is lower, catches -0 < +0
    end else if (a.fields.sign) begin
      lt = mag_gt;              // Both negative, bigger magnitude is lower
    end else begin
      lt = mag_lt;
    end
  end

  assign ord_eq = (a.raw == b.raw) | both_zero;  // +0 equals -0
  assign ord_lt = lt & ~both_zero;

  // ====================================================================
  // Result and invalid flag
  // ====================================================================
  always_comb begin
    cmp_true = 1'b0;
    flag_nv  = 1'b0;
    case (op)
      CMP_FEQ: begin
        cmp_true = ord_eq;
        flag_nv  = any_snan;    // Quiet compare, only sNaN traps
      end
      CMP_FLT: begin
        cmp_true = ord_lt;
        flag_nv  = any_nan;     // Signalling compare
      end
      CMP_FLE: begin
        cmp_true = ord_lt | ord_eq;
        flag_nv  = any_nan;
      end
      default: ;
    endcase
    if (any_nan) cmp_true = 1'b0;  // Unordered is never true
  end

endmodule

/* fp_classify.sv */
// Operand classifier
`timescale 1ns/1ps

module fp_classify (
  input  fpu_pkg::fp32_u    operand,
  output fpu_pkg::fp_info_t info,
  output logic [9:0]        class_mask
);
  import fpu_pkg::*;

  logic exp_zero;   // Exponent all zeros
  logic exp_ones;   // Exponent all ones
  logic man_zero;   // Mantissa all zeros
  logic quiet_bit;
  logic is_nan;

  // ====================================================================
  // Field decode
  // ====================================================================
  assign exp_zero  = (operand.fields.exponent == 8'h00);
  assign exp_ones  = (operand.fields.exponent == EXP_MAX);
  assign man_zero  = (operand.fields.mantissa == 23'd0);
  assign quiet_bit = operand.fields.mantissa[MAN_QUIET_BIT];
  assign is_nan    = exp_ones & ~man_zero;

  assign info.is_neg  = operand.fields.sign;
  assign info.is_inf  = exp_ones & man_zero;
  assign info.is_zero = exp_zero & man_zero;
  assign info.is_sub  = exp_zero & ~man_zero;   // Denormal, no hidden one
  assign info.is_norm = ~exp_zero & ~exp_ones;
  assign info.is_snan = is_nan & ~quiet_bit;
  assign info.is_qnan = is_nan & quiet_bit;

  // ====================================================================
  // FCLASS mask, RISC-V bit order
  // ====================================================================
  // Sign is ignored for NaN
  always_comb begin
    class_mask    = '0;
    class_mask[0] = info.is_neg & info.is_inf;
    class_mask[1] = info.is_neg & info.is_norm;
    class_mask[2] = info.is_neg & info.is_sub;
    class_mask[3] = info.is_neg & info.is_zero;
    class_mask[4] = ~info.is_neg & info.is_zero;
    class_mask[5] = ~info.is_neg & info.is_sub;
    class_mask[6] = ~info.is_neg & info.is_norm;
    class_mask[7] = ~info.is_neg & info.is_inf;
    class_mask[8] = info.is_snan;
    class_mask[9] = info.is_qnan;
  end

  // Exactly one bit is set for any input word
  // Subnormal and zero share exp_zero, split by man_zero
  // Normal excludes both exponent extremes

endmodule

/* fpu_pkg.sv */
// FPU shared types and constants
package fpu_pkg;

  // ====================================================================
  // Operation codes
  // ====================================================================
  // Arithmetic codes stay listed so they decode as unsupported
  typedef enum logic [4:0] {
    FP_ADD    = 5'd0,
    FP_SUB    = 5'd1,
    FP_MUL    = 5'd2,
    FP_DIV    = 5'd3,
    FP_SQRT   = 5'd4,
    FP_SGNJ   = 5'd5,
    FP_SGNJN  = 5'd6,
    FP_SGNJX  = 5'd7,
    FP_MIN    = 5'd8,
    FP_MAX    = 5'd9,
    FP_CVT    = 5'd10,
    FP_CMP    = 5'd11,
    FP_CLASS  = 5'd12,
    FP_FMA    = 5'd13,
    FP_FMSUB  = 5'd14,
    FP_FNMSUB = 5'd15,
    FP_FNMADD = 5'd16,
    FP_MV_XW  = 5'd17,  // FP bits to integer register
    FP_MV_WX  = 5'd18   // Integer bits to FP register
  } fp_op_e;

  // Compare kinds, decoded from funct3
  typedef enum logic [1:0] {
    CMP_FEQ = 2'd0,
    CMP_FLT = 2'd1,
    CMP_FLE = 2'd2
  } cmp_op_e;

  // Sign injection modes
  localparam logic [1:0] SGNJ_PLAIN = 2'd0;  // Sign of b
  localparam logic [1:0] SGNJ_NEG   = 2'd1;  // Inverted sign of b
  localparam logic [1:0] SGNJ_XOR   = 2'd2;  // Sign of a xor sign of b

  // ====================================================================
  // Single-precision word
  // ====================================================================
  localparam logic [7:0]  EXP_MAX       = 8'hFF;        // Inf / NaN exponent
  localparam int          MAN_QUIET_BIT = 22;           // Set for quiet NaN
  localparam logic [31:0] CANONICAL_NAN = 32'h7FC0_0000;

  typedef struct packed {
    logic        sign;
    logic [7:0]  exponent;
    logic [22:0] mantissa;
  } fp32_fields_t;

  // Raw bits or IEEE fields of the same word
  typedef union packed {
    logic [31:0]  raw;
    fp32_fields_t fields;
  } fp32_u;

  // Class facts of one operand
  typedef struct packed {
    logic is_neg;
    logic is_inf;
    logic is_zero;
    logic is_sub;   // Subnormal
    logic is_norm;
    logic is_snan;
    logic is_qnan;
  } fp_info_t;

  // ====================================================================
  // Request and response
  // ====================================================================
  typedef struct packed {
    fp_op_e      op;
    logic [2:0]  funct3;       // Compare kind for FP_CMP
    fp32_u       operand_a;    // rs1
    fp32_u       operand_b;    // rs2
    logic [31:0] int_operand;  // Integer source for FMV.W.X
  } fpu_req_t;

  typedef struct packed {
    logic [31:0] fp_result;
    logic [31:0] int_result;
    logic        flag_nv;      // Invalid operation
  } fpu_rsp_t;

endpackage
